// ==== rtl/cache_config.svh ====
/* Size settings for the blocking cache. Sizes must be powers of two
   and the cache always has 2 ways */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Capacity and message widths
`define CACHE_BYTES       256
`define CACHE_LINE_BITS   128
`define CACHE_WORD_BITS   32
`define CACHE_ADDR_BITS   32
`define CACHE_OPAQUE_BITS 8

// Sets per way
`define CACHE_SETS (`CACHE_BYTES * 8 / `CACHE_LINE_BITS / 2)

`endif

// ==== rtl/cache_pkg.sv ====
/* Types shared by the cache RTL. Widths come from cache_config.svh
   and the address split assumes word-aligned requests */
`default_nettype none
`include "cache_config.svh"

package cache_pkg;

  // --------------------
  // Width types
  typedef logic [`CACHE_ADDR_BITS-1:0]   addr_t;
  typedef logic [`CACHE_WORD_BITS-1:0]   word_t;
  typedef logic [`CACHE_LINE_BITS-1:0]   line_t;
  typedef logic [`CACHE_OPAQUE_BITS-1:0] opaque_t;
  typedef logic [$clog2(`CACHE_SETS)-1:0] idx_t;           // addr[6:4]
  typedef logic [`CACHE_ADDR_BITS-$clog2(`CACHE_SETS)
                 -$clog2(`CACHE_LINE_BITS/8)-1:0] tag_t;    // addr[31:7]
  typedef logic [$clog2(`CACHE_LINE_BITS/`CACHE_WORD_BITS)-1:0] word_sel_t;
  typedef logic [`CACHE_LINE_BITS/8-1:0] byte_en_t;        // One bit per line byte

  // --------------------
  // Messages
  typedef logic [2:0] msg_type_t;

  localparam msg_type_t MSG_READ  = 3'd0;
  localparam msg_type_t MSG_WRITE = 3'd1;

  typedef struct packed {
    msg_type_t msg_type;
    opaque_t   opaque;
    addr_t     addr;
    word_t     data;
  } cache_req_t;

  typedef struct packed {
    msg_type_t msg_type;
    opaque_t   opaque;
    word_t     data;
  } cache_resp_t;

  typedef struct packed {
    msg_type_t msg_type;
    addr_t     addr;      // Line aligned
    line_t     data;
  } mem_req_t;

  typedef struct packed {
    msg_type_t msg_type;
    line_t     data;
  } mem_resp_t;

  // --------------------
  // Controller states
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_TAG_CHECK,
    ST_WRITE_HIT,
    ST_EVICT_REQ,
    ST_EVICT_WAIT,
    ST_REFILL_REQ,
    ST_REFILL_WAIT,
    ST_REFILL_UPDATE,
    ST_RESP
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/cache_way.sv ====
/* One cache way. Tag and data reads are registered, so a read enabled in
   cycle N shows up in cycle N+1. Only valid and dirty bits are reset */
`timescale 1ns/1ps
`default_nettype none
`include "cache_config.svh"

module cache_way (
  input  logic                clk,
  input  logic                rst_n,
  input  cache_pkg::addr_t    req_addr,
  input  logic                tag_ren,
  input  logic                tag_wen,
  input  logic                data_ren,
  input  logic                data_wen,
  input  cache_pkg::line_t    write_line,
  input  cache_pkg::byte_en_t wben,
  input  logic                read_reg_en,
  input  logic                evict_addr_en,
  input  logic                memreq_addr_sel,
  output logic                tag_match,
  output logic                dirty,
  output cache_pkg::word_t    read_word,
  output cache_pkg::line_t    line_out,
  output cache_pkg::addr_t    memreq_addr
);
  import cache_pkg::*;

  localparam int OFF_BITS  = $clog2(`CACHE_LINE_BITS / 8);
  localparam int WOFF_BITS = $clog2(`CACHE_WORD_BITS / 8);

  idx_t      idx;
  tag_t      tag;
  word_sel_t word_sel;

  logic [`CACHE_SETS-1:0] valid_q;
  logic [`CACHE_SETS-1:0] dirty_bits_q;
  tag_t                   tag_array [`CACHE_SETS];
  line_t                  data_array [`CACHE_SETS];

  logic  match_q;
  logic  dirty_q;
  tag_t  tag_q;
  line_t data_q;
  line_t read_q;
  addr_t evict_addr_q;
  line_t merged_line;

  assign idx      = req_addr[OFF_BITS +: $bits(idx_t)];
  assign tag      = req_addr[`CACHE_ADDR_BITS-1 -: $bits(tag_t)];
  assign word_sel = req_addr[WOFF_BITS +: $bits(word_sel_t)];

  // Byte merge of the write line into the stored line
  always_comb begin
    merged_line = data_array[idx];
    for (int b = 0; b < $bits(byte_en_t); b++) begin
      if (wben[b]) merged_line[8*b +: 8] = write_line[8*b +: 8];
    end
  end

  // --------------------
  // State bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q      <= '0;
      dirty_bits_q <= '0;
      match_q      <= 1'b0;
      dirty_q      <= 1'b0;
    end else begin
      if (tag_wen) valid_q[idx] <= 1'b1;
      if (data_wen) dirty_bits_q[idx] <= ~&wben;   // Full refill leaves it clean
      if (tag_ren) begin
        match_q <= valid_q[idx] && (tag_array[idx] == tag);
        dirty_q <= valid_q[idx] && dirty_bits_q[idx];
      end
    end
  end

  // --------------------
  // Arrays and read path
  always_ff @(posedge clk) begin
    if (tag_wen) tag_array[idx] <= tag;
    if (data_wen) data_array[idx] <= merged_line;
    if (tag_ren) tag_q <= tag_array[idx];
    if (data_ren) data_q <= data_array[idx];
    // A refill loads the new line straight into the read register
    if (read_reg_en) read_q <= data_wen ? merged_line : data_q;
    if (evict_addr_en) evict_addr_q <= {tag_q, idx, {OFF_BITS{1'b0}}};
  end

  assign tag_match   = match_q;
  assign dirty       = dirty_q;
  assign read_word   = read_q[word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];
  assign line_out    = read_q;
  assign memreq_addr = memreq_addr_sel ? {tag, idx, {OFF_BITS{1'b0}}} // Refill
                                       : evict_addr_q;                 // Victim

endmodule

`default_nettype wire

// ==== rtl/cache_dpath.sv ====
/* Cache datapath with request capture, two ways and message packing.
   The lookup uses the incoming address in the capture cycle */
`timescale 1ns/1ps
`default_nettype none
`include "cache_config.svh"

module cache_dpath (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cachereq_en,
  input  cache_pkg::cache_req_t  cachereq_msg,
  input  logic                   memresp_en,
  input  cache_pkg::mem_resp_t   memresp_msg,
  input  logic                   req_capture_en,
  input  logic                   tag_ren,
  input  logic                   data_ren,
  input  logic [1:0]             tag_wen,
  input  logic [1:0]             data_wen,
  input  cache_pkg::byte_en_t    wben,
  input  logic                   write_sel,
  input  logic                   read_reg_en,
  input  logic                   evict_addr_en,
  input  logic                   way_sel,
  input  logic                   memreq_addr_sel,
  input  cache_pkg::msg_type_t   cacheresp_type,
  input  cache_pkg::msg_type_t   memreq_type,
  output logic [1:0]             tag_match,
  output logic                   victim_dirty,
  output cache_pkg::idx_t        req_idx,
  output cache_pkg::msg_type_t   req_type,
  output cache_pkg::cache_resp_t cacheresp_msg,
  output cache_pkg::mem_req_t    memreq_msg
);
  import cache_pkg::*;

  localparam int OFF_BITS  = $clog2(`CACHE_LINE_BITS / 8);
  localparam int WOFF_BITS = $clog2(`CACHE_WORD_BITS / 8);
  localparam int WORDS     = `CACHE_LINE_BITS / `CACHE_WORD_BITS;

  cache_req_t req_q;
  line_t      refill_q;
  addr_t      lookup_addr;
  word_sel_t  word_sel;
  line_t      write_line;
  byte_en_t   way_wben;

  logic [1:0] way_dirty;
  word_t      way_word [2];
  line_t      way_line [2];
  addr_t      way_addr [2];

  // --------------------
  // Input side
  always_ff @(posedge clk) begin
    if (req_capture_en) req_q <= cachereq_msg;
    if (memresp_en) refill_q <= memresp_msg.data;
  end

  assign lookup_addr = cachereq_en ? cachereq_msg.addr : req_q.addr;
  assign req_idx     = req_q.addr[OFF_BITS +: $bits(idx_t)];
  assign req_type    = req_q.msg_type;
  assign word_sel    = req_q.addr[WOFF_BITS +: $bits(word_sel_t)];

  assign write_line = write_sel ? refill_q : {WORDS{req_q.data}};
  // Word writes get a one-word mask, moved here to the request word
  assign way_wben = write_sel ? wben
                              : byte_en_t'(wben << (word_sel * (`CACHE_WORD_BITS / 8)));

  // --------------------
  // Ways
  for (genvar w = 0; w < 2; w++) begin : g_way
    cache_way u_way (
      .clk             (clk),
      .rst_n           (rst_n),
      .req_addr        (lookup_addr),
      .tag_ren         (tag_ren),
      .tag_wen         (tag_wen[w]),
      .data_ren        (data_ren),
      .data_wen        (data_wen[w]),
      .write_line      (write_line),
      .wben            (way_wben),
      .read_reg_en     (read_reg_en),
      .evict_addr_en   (evict_addr_en),
      .memreq_addr_sel (memreq_addr_sel),
      .tag_match       (tag_match[w]),
      .dirty           (way_dirty[w]),
      .read_word       (way_word[w]),
      .line_out        (way_line[w]),
      .memreq_addr     (way_addr[w])
    );
  end

  // --------------------
  // Output side
  assign victim_dirty = way_dirty[way_sel];

  assign cacheresp_msg.msg_type = cacheresp_type;
  assign cacheresp_msg.opaque   = req_q.opaque;
  assign cacheresp_msg.data     = way_word[way_sel];

  assign memreq_msg.msg_type = memreq_type;
  assign memreq_msg.addr     = {way_addr[way_sel][`CACHE_ADDR_BITS-1:OFF_BITS],
                                {OFF_BITS{1'b0}}};
  assign memreq_msg.data     = way_line[way_sel];   // Victim line on eviction

  a_one_way_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(&data_wen))
    else $error("data write enabled in both ways");

endmodule

`default_nettype wire

// ==== rtl/cache_ctrl.sv ====
/* Cache controller FSM and LRU bits. One request at a time; the next
   request is only legal after cacheresp_en */
`timescale 1ns/1ps
`default_nettype none
`include "cache_config.svh"

module cache_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cachereq_en,
  input  logic                 memresp_en,
  input  logic [1:0]           tag_match,
  input  logic                 victim_dirty,
  input  cache_pkg::idx_t      req_idx,
  input  cache_pkg::msg_type_t req_type,
  output logic                 req_capture_en,
  output logic                 tag_ren,
  output logic                 data_ren,
  output logic [1:0]           tag_wen,
  output logic [1:0]           data_wen,
  output cache_pkg::byte_en_t  wben,
  output logic                 write_sel,
  output logic                 read_reg_en,
  output logic                 evict_addr_en,
  output logic                 way_sel,
  output logic                 memreq_addr_sel,
  output cache_pkg::msg_type_t cacheresp_type,
  output cache_pkg::msg_type_t memreq_type,
  output logic                 cacheresp_en,
  output logic                 memreq_en
);
  import cache_pkg::*;

  ctrl_state_t            state_q;
  ctrl_state_t            state_d;
  logic [`CACHE_SETS-1:0] lru_q;   // Way to evict next, per set
  logic                   way_q;
  logic                   hit;
  logic                   is_write;

  assign hit      = |tag_match;
  assign is_write = (req_type == MSG_WRITE);

  // Way is decided in tag check and held after it
  assign way_sel = (state_q == ST_TAG_CHECK) ? (hit ? tag_match[1] : lru_q[req_idx])
                                             : way_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      lru_q   <= '0;
      way_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_TAG_CHECK) begin
        lru_q[req_idx] <= ~way_sel;   // Other way becomes the victim
        way_q          <= way_sel;
      end
    end
  end

  // --------------------
  // Next state and outputs
  always_comb begin
    state_d         = state_q;
    req_capture_en  = 1'b0;
    tag_ren         = 1'b0;
    data_ren        = 1'b0;
    tag_wen         = 2'b00;
    data_wen        = 2'b00;
    wben            = '0;
    write_sel       = 1'b0;
    read_reg_en     = 1'b0;
    evict_addr_en   = 1'b0;
    memreq_addr_sel = 1'b0;
    cacheresp_type  = MSG_READ;
    memreq_type     = MSG_READ;
    cacheresp_en    = 1'b0;
    memreq_en       = 1'b0;
    unique case (state_q)
      ST_IDLE: begin
        req_capture_en = cachereq_en;
        tag_ren        = cachereq_en;   // Lookup starts with the capture
        data_ren       = cachereq_en;
        if (cachereq_en) state_d = ST_TAG_CHECK;
      end
      ST_TAG_CHECK: begin
        read_reg_en   = 1'b1;
        evict_addr_en = 1'b1;
        if (hit) state_d = is_write ? ST_WRITE_HIT : ST_RESP;
        else state_d = victim_dirty ? ST_EVICT_REQ : ST_REFILL_REQ;
      end
      ST_WRITE_HIT: begin
        // Also merges the word after a write miss refill
        data_wen = 2'b01 << way_q;
        wben     = byte_en_t'({(`CACHE_WORD_BITS / 8){1'b1}});
        state_d  = ST_RESP;
      end
      ST_EVICT_REQ: begin
        memreq_en   = 1'b1;
        memreq_type = MSG_WRITE;
        state_d     = ST_EVICT_WAIT;
      end
      ST_EVICT_WAIT: begin
        if (memresp_en) state_d = ST_REFILL_REQ;
      end
      ST_REFILL_REQ: begin
        memreq_en       = 1'b1;
        memreq_addr_sel = 1'b1;
        state_d         = ST_REFILL_WAIT;
      end
      ST_REFILL_WAIT: begin
        memreq_addr_sel = 1'b1;
        if (memresp_en) state_d = ST_REFILL_UPDATE;
      end
      ST_REFILL_UPDATE: begin
        tag_wen     = 2'b01 << way_q;
        data_wen    = 2'b01 << way_q;
        wben        = '1;
        write_sel   = 1'b1;
        read_reg_en = 1'b1;
        state_d     = is_write ? ST_WRITE_HIT : ST_RESP;
      end
      ST_RESP: begin
        cacheresp_en   = 1'b1;
        cacheresp_type = req_type;
        state_d        = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // --------------------
  // Protocol checks
  a_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cachereq_en |-> state_q == ST_IDLE)
    else $error("cache request while busy");

  a_resp_wait: assert property (@(posedge clk) disable iff (!rst_n)
    memresp_en |-> state_q inside {ST_EVICT_WAIT, ST_REFILL_WAIT})
    else $error("memory response without a pending request");

  a_one_match: assert property (@(posedge clk) disable iff (!rst_n)
    state_q == ST_TAG_CHECK |-> tag_match != 2'b11)
    else $error("tag hit in both ways");

endmodule

`default_nettype wire

// ==== rtl/blocking_cache.sv ====
/* Two-way write-back blocking cache. Messages move on one-cycle enables
   with no back-pressure on either side */
`timescale 1ns/1ps
`default_nettype none

module blocking_cache (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cachereq_en,
  input  cache_pkg::cache_req_t  cachereq_msg,
  output logic                   cacheresp_en,
  output cache_pkg::cache_resp_t cacheresp_msg,
  output logic                   memreq_en,
  output cache_pkg::mem_req_t    memreq_msg,
  input  logic                   memresp_en,
  input  cache_pkg::mem_resp_t   memresp_msg
);
  import cache_pkg::*;

  // Controller to datapath
  logic       req_capture_en;
  logic       tag_ren;
  logic       data_ren;
  logic [1:0] tag_wen;
  logic [1:0] data_wen;
  byte_en_t   wben;
  logic       write_sel;
  logic       read_reg_en;
  logic       evict_addr_en;
  logic       way_sel;
  logic       memreq_addr_sel;
  msg_type_t  cacheresp_type;
  msg_type_t  memreq_type;

  // Datapath status
  logic [1:0] tag_match;
  logic       victim_dirty;
  idx_t       req_idx;
  msg_type_t  req_type;

  cache_ctrl u_ctrl (.*);

  cache_dpath u_dpath (.*);

endmodule

`default_nettype wire

// ==== testbench/tb_blocking_cache.sv ====
/* Random word reads and writes against a reference LRU model. Requests use
   3 tags per set, so most sets see evictions. Memory latency is 1 to 4 cycles */
`timescale 1ns/1ps
`default_nettype none
`include "cache_config.svh"

module tb_blocking_cache;
  import cache_pkg::*;

  localparam logic [31:0] SEED      = 32'hfbe2d8eb;
  localparam int          NUM_TESTS = 400;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        cachereq_en;
  cache_req_t  cachereq_msg;
  logic        cacheresp_en;
  cache_resp_t cacheresp_msg;
  logic        memreq_en;
  mem_req_t    memreq_msg;
  logic        memresp_en;
  mem_resp_t   memresp_msg;

  logic [31:0] lfsr_q = SEED;
  int          cycle = 0;
  int          errors = 0;
  mem_req_t    seen_q[$];          // Memory requests of the current access
  line_t       mem [addr_t];        // Memory model, line addressed
  word_t       truth [addr_t];      // Latest value of every written word

  // Reference cache state
  tag_t m_tag [`CACHE_SETS][2];
  logic m_valid [`CACHE_SETS][2];
  logic m_dirty [`CACHE_SETS][2];
  logic m_lru [`CACHE_SETS];         // Way to evict next

  blocking_cache u_blocking_cache (
    .clk           (clk),
    .rst_n         (rst_n),
    .cachereq_en   (cachereq_en),
    .cachereq_msg  (cachereq_msg),
    .cacheresp_en  (cacheresp_en),
    .cacheresp_msg (cacheresp_msg),
    .memreq_en     (memreq_en),
    .memreq_msg    (memreq_msg),
    .memresp_en    (memresp_en),
    .memresp_msg   (memresp_msg)
  );

  always #5 clk = ~clk;
  always @(posedge clk) cycle <= cycle + 1;

  // --------------------
  // Helpers
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic word_t init_word(input addr_t a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  function automatic word_t truth_word(input addr_t a);
    return truth.exists(a) ? truth[a] : init_word(a);
  endfunction

  function automatic line_t truth_line(input addr_t la);
    line_t l;
    for (int k = 0; k < 4; k++) l[32*k +: 32] = truth_word(la + 4 * k);   // Word 0 in low bits
    return l;
  endfunction

  function automatic line_t mem_line(input addr_t la);
    line_t l;
    for (int k = 0; k < 4; k++) l[32*k +: 32] = init_word(la + 4 * k);
    return mem.exists(la) ? mem[la] : l;
  endfunction

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Same LRU and write-back rules as the cache, one access at a time
  task automatic model_access(input addr_t addr, input logic is_write, input word_t wdata,
                              output logic hit, output logic wb, output addr_t wb_addr,
                              output line_t wb_line);
    idx_t idx;
    tag_t tag;
    logic way;
    int   w;
    idx     = addr[6:4];
    tag     = addr[31:7];
    hit     = 1'b0;
    wb      = 1'b0;
    wb_addr = '0;
    wb_line = '0;
    way     = m_lru[idx];
    for (w = 0; w < 2; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (!hit) begin
      wb      = m_valid[idx][way] && m_dirty[idx][way];   // Invalid or clean needs no write
      wb_addr = {m_tag[idx][way], idx, 4'b0000};
      wb_line = truth_line(wb_addr);
      m_valid[idx][way] = 1'b1;
      m_tag[idx][way]   = tag;
      m_dirty[idx][way] = 1'b0;
    end
    m_lru[idx] = ~way;
    if (is_write) begin
      m_dirty[idx][way] = 1'b1;
      truth[addr]       = wdata;
    end
  endtask

  // --------------------
  // Memory model
  always begin : mem_model
    mem_req_t    req;
    line_t       rdata;
    int unsigned delay;
    @(negedge clk);
    if (memreq_en) begin
      req = memreq_msg;
      seen_q.push_back(req);
      rdata = '0;
      if (req.msg_type == MSG_WRITE) mem[req.addr] = req.data;
      else rdata = mem_line(req.addr);
      delay = rand_bits(2) + 1;
      repeat (delay) @(posedge clk);
      #1;
      memresp_en           = 1'b1;
      memresp_msg.msg_type = req.msg_type;
      memresp_msg.data     = rdata;
      @(posedge clk);
      #1 memresp_en = 1'b0;
    end
  end

  // --------------------
  // Requests and checks
  initial begin : driver
    cache_resp_t resp;
    addr_t       addr;
    addr_t       wb_addr;
    line_t       wb_line;
    word_t       wdata;
    opaque_t     opq;
    logic        is_write;
    logic        hit;
    logic        wb;
    logic [1:0]  tsel;
    int          req_cycle;
    int          hits;
    int          wbs;
    int          n_mem;
    rst_n        = 1'b0;
    cachereq_en  = 1'b0;
    cachereq_msg = '0;
    memresp_en   = 1'b0;
    memresp_msg  = '0;
    hits         = 0;
    wbs          = 0;
    for (int s = 0; s < `CACHE_SETS; s++) begin
      m_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w]   = '0;
      end
    end
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    check(cacheresp_en, 1'b0, "cacheresp_en after reset");
    check(memreq_en, 1'b0, "memreq_en after reset");

    for (int t = 0; t < NUM_TESTS; t++) begin
      is_write = rand_bits(1);
      tsel     = rand_bits(2) % 3;
      addr     = (tsel == 0) ? 32'h0000_1000 : (tsel == 1) ? 32'h8000_0400 : 32'h7fff_ff80;
      addr     = addr | {25'b0, 3'(rand_bits(3)), 4'b0000} | (rand_bits(2) << 2);
      wdata    = rand_bits(32);
      opq      = rand_bits(8);
      model_access(addr, is_write, wdata, hit, wb, wb_addr, wb_line);
      hits += hit;
      wbs  += wb;

      @(posedge clk);
      #1;
      cachereq_en           = 1'b1;
      cachereq_msg.msg_type = is_write ? MSG_WRITE : MSG_READ;
      cachereq_msg.opaque   = opq;
      cachereq_msg.addr     = addr;
      cachereq_msg.data     = wdata;
      req_cycle             = cycle;
      @(posedge clk);
      #1 cachereq_en = 1'b0;
      do @(negedge clk); while (!cacheresp_en);
      resp = cacheresp_msg;

      check(resp.opaque, opq, "response opaque");
      check(resp.msg_type, is_write ? MSG_WRITE : MSG_READ, "response type");
      if (!is_write) check(resp.data, truth_word(addr), $sformatf("read data at %h", addr));
      if (hit) check(cycle - req_cycle, is_write ? 3 : 2, "hit latency in cycles");
      n_mem = hit ? 0 : (wb ? 2 : 1);
      check(seen_q.size(), n_mem, "memory requests per access");
      if (seen_q.size() == n_mem && n_mem > 0) begin
        if (wb) begin
          check(seen_q[0].msg_type, MSG_WRITE, "write-back type");
          check(seen_q[0].addr, wb_addr, "write-back address");
          check(seen_q[0].data, wb_line, "write-back line");
        end
        check(seen_q[n_mem-1].msg_type, MSG_READ, "refill type");
        check(seen_q[n_mem-1].addr, {addr[31:4], 4'b0000}, "refill address");
      end
      seen_q.delete();
    end

    $display("Done with %0d requests, %0d hits, %0d write-backs, %0d errors",
             NUM_TESTS, hits, wbs, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Each access takes well under 100 cycles
  initial begin : watchdog
    repeat (NUM_TESTS * 100) @(posedge clk);
    $display("The run timed out before all requests were answered");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== blocking_cache.f ====
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_way.sv
rtl/cache_dpath.sv
rtl/cache_ctrl.sv
rtl/blocking_cache.sv
testbench/tb_blocking_cache.sv

// ==== Bender.yml ====
package:
  name: blocking_cache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cache_pkg.sv
      - rtl/cache_way.sv
      - rtl/cache_dpath.sv
      - rtl/cache_ctrl.sv
      - rtl/blocking_cache.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_blocking_cache.sv
